// File: source/st_mem_defs.svh
/*
 * memory subsystem constants
 * widths, download credit depth, ROM bases and Viking window tags
 */
`ifndef ST_MEM_DEFS_SVH
`define ST_MEM_DEFS_SVH

`default_nettype none

// word address covers bits 23:1
`define ST_ADDR_W 23
`define ST_DATA_W 16

// loader buffer depth, also the host's starting credit count
`define ST_DL_CREDITS 4

// byte bases of the download targets
`define ST_TOS256_BASE 24'hE00000
`define ST_TOS192_BASE 24'hFC0000
`define ST_CART_BASE 24'hFA0000

// address bits 23:18 of the Viking frame buffer
`define ST_VIKING_LO_TAG 6'b110000
`define ST_VIKING_HI_TAG 6'b111010

// window accesses before the driver counts as loaded
`define ST_VIKING_HITS 8'd255

`default_nettype wire

`endif

// File: source/st_cfg_pkg.sv
/*
 * configuration types
 * memory size selection and host download targets
 */
`default_nettype none

package st_cfg_pkg;

	// installed ST RAM, order matters for the size compare in the top
	typedef enum logic [2:0] {
		MEM_512K = 3'd0,
		MEM_1M   = 3'd1,
		MEM_2M   = 3'd2,
		MEM_4M   = 3'd3,
		MEM_8M   = 3'd4,
		MEM_14M  = 3'd5
	} mem_size_e;

	// what the host is downloading
	typedef enum logic [2:0] {
		DL_TOS256  = 3'd0,
		DL_TOS192  = 3'd1,
		DL_CART    = 3'd2,
		DL_CLEAR   = 3'd3,
		DL_POINTER = 3'd4
	} dl_target_e;

endpackage

`default_nettype wire

// File: source/st_bus_pkg.sv
/*
 * bus side types
 * 8 MHz slot position and SDRAM request source
 */
`default_nettype none

package st_bus_pkg;

	// four strobes make one bus cycle
	typedef enum logic [1:0] {
		SLOT_PRE = 2'd0,
		SLOT_1   = 2'd1,
		SLOT_2   = 2'd2,
		SLOT_3   = 2'd3
	} bus_slot_e;

	// owner of the current SDRAM request
	typedef enum logic [1:0] {
		SRC_NONE    = 2'd0,
		SRC_CHIPSET = 2'd1,
		SRC_LOADER  = 2'd2,
		SRC_VIKING  = 2'd3
	} req_src_e;

endpackage

`default_nettype wire

// File: source/st_ram_window.sv
/*
 * RAM window decoder
 * flags chipset addresses inside installed RAM or the Viking frame buffer
 */
`timescale 1ns/10ps
`include "st_mem_defs.svh"
`default_nettype none

module st_ram_window
	import st_cfg_pkg::*;
(
	input  logic [`ST_ADDR_W:1] ram_addr_i,
	input  mem_size_e           mem_size_i,
	input  logic                viking_enable_i,
	input  logic                steroids_i,
	output logic                ram_en_o
);

	logic in_ram;
	logic in_viking;

	// populated ST RAM for each size
	always_comb begin
		case (mem_size_i)
			MEM_512K: in_ram = ram_addr_i[23:19] == 5'b00000;
			MEM_1M:   in_ram = ram_addr_i[23:20] == 4'b0000;
			MEM_2M:   in_ram = ram_addr_i[23:21] == 3'b000;
			MEM_4M:   in_ram = ram_addr_i[23:22] == 2'b00;
			MEM_8M:   in_ram = !ram_addr_i[23];
			// everything below the E00000 rom and io area
			MEM_14M:  in_ram = !(ram_addr_i[23] && ram_addr_i[22] && ram_addr_i[21]);
			default:  in_ram = 1'b0;
		endcase
	end

	// frame buffer at C0xxxx, or E8xxxx in steroids mode
	assign in_viking = viking_enable_i &&
		ram_addr_i[23:18] == (steroids_i ? `ST_VIKING_HI_TAG : `ST_VIKING_LO_TAG);

	assign ram_en_o = in_ram || in_viking;

endmodule

`default_nettype wire

// File: source/st_dl_loader.sv
/*
 * host download loader
 * turns the download stream into addressed words with credit return
 */
`timescale 1ns/10ps
`include "st_mem_defs.svh"
`default_nettype none

module st_dl_loader
	import st_cfg_pkg::*;
(
	input  logic                  clk_32,
	input  logic                  xsint,
	input  logic                  dl_start_i,
	input  dl_target_e            dl_target_i,
	input  logic                  ioctl_wr_i,
	input  logic [24:0]           ioctl_addr_i,
	input  logic [15:0]           ioctl_dout_i,
	input  logic                  dl_end_i,
	input  logic                  dl_word_take_i,
	output logic                  dl_credit_o,
	output logic                  dl_busy_o,
	output logic                  dl_word_valid_o,
	output logic [`ST_ADDR_W:1]   dl_word_addr_o,
	output logic [`ST_DATA_W-1:0] dl_word_data_o,
	output logic [`ST_ADDR_W:1]   dl_cur_addr_o
);

	localparam int DEPTH = `ST_DL_CREDITS;
	localparam int PTR_W = $clog2(DEPTH);
	localparam logic [23:0] TOS256_BASE = `ST_TOS256_BASE;
	localparam logic [23:0] TOS192_BASE = `ST_TOS192_BASE;
	localparam logic [23:0] CART_BASE = `ST_CART_BASE;

	dl_target_e            tgt_q;
	logic                  busy_q;
	logic [`ST_ADDR_W:1]   addr_q;
	logic [`ST_ADDR_W:1]   addr_nx;
	logic [15:0]           ptr_lo_q;
	logic [`ST_ADDR_W:1]   buf_addr [DEPTH];
	logic [`ST_DATA_W-1:0] buf_data [DEPTH];
	logic [PTR_W-1:0]      wr_ptr_q;
	logic [PTR_W-1:0]      rd_ptr_q;
	logic [PTR_W:0]        cnt_q;
	logic                  wr_ok;
	logic                  hdr_wr;
	logic                  push;
	logic                  pop;

	assign wr_ok = ioctl_wr_i && busy_q;
	// first two words of a pointer download carry the address
	assign hdr_wr  = wr_ok && tgt_q == DL_POINTER && ioctl_addr_i[24:2] == '0;
	assign push    = wr_ok && !hdr_wr;
	assign pop     = dl_word_take_i && cnt_q != '0;
	assign addr_nx = addr_q + 1'b1;

	////////////////////////////////////////////////////////////
	// address generation
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			busy_q <= 1'b0;
			tgt_q  <= DL_TOS256;
			addr_q <= '0;
		end else begin
			if (dl_end_i) begin
				busy_q <= 1'b0;
			end
			if (dl_start_i) begin
				busy_q <= 1'b1;
				tgt_q  <= dl_target_i;
				// one word below the base, each data word pre-increments
				case (dl_target_i)
					DL_TOS256: addr_q <= TOS256_BASE[23:1] - 1'b1;
					DL_TOS192: addr_q <= TOS192_BASE[23:1] - 1'b1;
					DL_CART:   addr_q <= CART_BASE[23:1] - 1'b1;
					// clear and pointer start low, away from the rom windows
					default:   addr_q <= '0;
				endcase
			end else if (hdr_wr && ioctl_addr_i[1]) begin
				addr_q <= {ioctl_dout_i[6:0], ptr_lo_q} - 1'b1;
			end else if (push) begin
				addr_q <= addr_nx;
			end
		end
	end

	// low pointer half waits for the high half
	always_ff @(posedge clk_32) begin
		if (hdr_wr && !ioctl_addr_i[1]) begin
			ptr_lo_q <= ioctl_dout_i;
		end
	end

	////////////////////////////////////////////////////////////
	// word buffer
	////////////////////////////////////////////////////////////

	// host sends big endian, swap into bus order
	always_ff @(posedge clk_32) begin
		if (push) begin
			buf_addr[wr_ptr_q] <= addr_nx;
			buf_data[wr_ptr_q] <= {ioctl_dout_i[7:0], ioctl_dout_i[15:8]};
		end
	end

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			wr_ptr_q    <= '0;
			rd_ptr_q    <= '0;
			cnt_q       <= '0;
			dl_credit_o <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			cnt_q <= cnt_q + (push ? 1'b1 : 1'b0) - (pop ? 1'b1 : 1'b0);
			// headers arrive with an empty buffer so pop never collides
			dl_credit_o <= pop || hdr_wr;
		end
	end

	assign dl_word_valid_o = cnt_q != '0;
	assign dl_word_addr_o  = buf_addr[rd_ptr_q];
	assign dl_word_data_o  = buf_data[rd_ptr_q];
	// stays busy until the last buffered word has gone out
	assign dl_busy_o       = busy_q || dl_word_valid_o;
	assign dl_cur_addr_o   = addr_q;

	// host respects the credit count
	a_no_overrun: assert property (@(posedge clk_32) disable iff (!xsint)
		ioctl_wr_i |-> cnt_q != (PTR_W + 1)'(DEPTH));

endmodule

`default_nettype wire

// File: source/st_viking_detect.sv
/*
 * Viking driver detection
 * counts cpu accesses to the frame buffer until the driver counts as loaded
 */
`timescale 1ns/10ps
`include "st_mem_defs.svh"
`default_nettype none

module st_viking_detect (
	input  logic                clk_32,
	input  logic                xsint,
	input  logic                mhz8_en_i,
	input  logic                cpu_as_n_i,
	input  logic [`ST_ADDR_W:1] cpu_addr_i,
	input  logic                viking_enable_i,
	input  logic                steroids_i,
	output logic                viking_active_o
);

	logic [7:0] hits_q;
	logic       in_win;

	// strobed cpu cycle inside the frame buffer
	// stray probes from other software stay well below the limit
	assign in_win = !cpu_as_n_i && viking_enable_i &&
		cpu_addr_i[23:18] == (steroids_i ? `ST_VIKING_HI_TAG : `ST_VIKING_LO_TAG);

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			hits_q          <= '0;
			viking_active_o <= 1'b0;
		end else begin
			// saturate at the limit
			if (mhz8_en_i && in_win && hits_q != `ST_VIKING_HITS) begin
				hits_q <= hits_q + 1'b1;
			end
			viking_active_o <= hits_q == `ST_VIKING_HITS;
		end
	end

endmodule

`default_nettype wire

// File: source/st_rom_map.sv
/*
 * ROM address map
 * tracks which TOS image was loaded and moves ROM accesses to its base
 */
`timescale 1ns/10ps
`include "st_mem_defs.svh"
`default_nettype none

module st_rom_map (
	input  logic                clk_32,
	input  logic                xsint,
	input  logic                dl_busy_i,
	input  logic [`ST_ADDR_W:1] dl_cur_addr_i,
	input  logic                rom2_n_i,
	input  logic [`ST_ADDR_W:1] cpu_addr_i,
	output logic                tos192k_o,
	output logic [`ST_ADDR_W:1] rom_addr_o
);

	localparam logic [23:0] TOS256_BASE = `ST_TOS256_BASE;
	localparam logic [23:0] TOS192_BASE = `ST_TOS192_BASE;

	// FC0000 and up means a 192k image, Ex means 256k
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			tos192k_o <= 1'b0;
		end else if (dl_busy_i) begin
			if (dl_cur_addr_i[23:18] == TOS192_BASE[23:18]) begin
				tos192k_o <= 1'b1;
			end else if (dl_cur_addr_i[23:20] == TOS256_BASE[23:20]) begin
				tos192k_o <= 1'b0;
			end
		end
	end

	// rom2 select gets the image base, offset kept
	always_comb begin
		rom_addr_o = cpu_addr_i;
		if (!rom2_n_i) begin
			rom_addr_o = tos192k_o ? {TOS192_BASE[23:18], cpu_addr_i[17:1]} :
				{TOS256_BASE[23:18], cpu_addr_i[17:1]};
		end
	end

endmodule

`default_nettype wire

// File: source/st_slot_ctrl.sv
/*
 * bus cycle sequencer
 * steps the four bus slots and grants the SDRAM port to one source per slot
 */
`timescale 1ns/10ps
`include "st_mem_defs.svh"
`default_nettype none

module st_slot_ctrl
	import st_bus_pkg::*;
(
	input  logic                  clk_32,
	input  logic                  xsint,
	input  logic                  mhz8_en_i,
	input  logic                  turbo_i,
	input  logic                  ram_ras_n_i,
	input  logic                  ram_we_n_i,
	input  logic                  ram_uds_i,
	input  logic                  ram_lds_i,
	input  logic [`ST_ADDR_W:1]   ram_addr_i,
	input  logic [`ST_DATA_W-1:0] ram_din_i,
	input  logic                  ram_en_i,
	input  logic                  dl_busy_i,
	input  logic                  dl_word_valid_i,
	input  logic [`ST_ADDR_W:1]   dl_word_addr_i,
	input  logic [`ST_DATA_W-1:0] dl_word_data_i,
	output logic                  dl_word_take_o,
	input  logic                  viking_active_i,
	input  logic                  viking_read_i,
	input  logic [`ST_ADDR_W:1]   viking_addr_i,
	output bus_slot_e             slot_o,
	output logic                  sdram_req_o,
	output logic                  sdram_we_o,
	output logic [1:0]            sdram_ds_o,
	output logic [`ST_ADDR_W:1]   sdram_addr_o,
	output logic [`ST_DATA_W-1:0] sdram_din_o,
	output req_src_e              sdram_src_o
);

	bus_slot_e             slot_q;
	bus_slot_e             slot_nx;
	logic                  cpu_slot;
	logic                  viking_slot;
	logic                  ras_n_d;
	logic                  pend_q;
	logic                  pend_we_q;
	logic [1:0]            pend_ds_q;
	logic [`ST_ADDR_W:1]   pend_addr_q;
	logic [`ST_DATA_W-1:0] pend_din_q;
	req_src_e              win_src;

	////////////////////////////////////////////////////////////
	// slot sequencing
	////////////////////////////////////////////////////////////

	// the grant is decided for the slot being entered
	assign slot_nx = bus_slot_e'(slot_q + 2'd1);

	// turbo moves the cpu one slot later and the video fetch too
	assign cpu_slot    = (slot_nx == SLOT_1 && !turbo_i) || (slot_nx == SLOT_2 && turbo_i);
	assign viking_slot = (slot_nx == SLOT_2 && !turbo_i) || (slot_nx == SLOT_3 && turbo_i);

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			slot_q <= SLOT_PRE;
		end else if (mhz8_en_i) begin
			slot_q <= slot_nx;
		end
	end

	assign slot_o = slot_q;

	////////////////////////////////////////////////////////////
	// chipset request latch
	////////////////////////////////////////////////////////////

	// ras falling edge starts an access
	// refresh (address zero) and unpopulated addresses never get latched
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			ras_n_d <= 1'b1;
			pend_q  <= 1'b0;
		end else begin
			ras_n_d <= ram_ras_n_i;
			if (mhz8_en_i && win_src == SRC_CHIPSET) begin
				pend_q <= 1'b0;
			end
			// a new edge wins over a grant in the same cycle
			if (ras_n_d && !ram_ras_n_i && ram_en_i && |ram_addr_i) begin
				pend_q <= 1'b1;
			end
		end
	end

	// payload of the pending access
	always_ff @(posedge clk_32) begin
		if (ras_n_d && !ram_ras_n_i && ram_en_i && |ram_addr_i) begin
			pend_we_q   <= ~ram_we_n_i;
			pend_ds_q   <= {ram_uds_i, ram_lds_i};
			pend_addr_q <= ram_addr_i;
			pend_din_q  <= ram_din_i;
		end
	end

	////////////////////////////////////////////////////////////
	// arbitration
	////////////////////////////////////////////////////////////

	always_comb begin
		win_src = SRC_NONE;
		if (cpu_slot) begin
			// downloads own the cpu slot
			if (dl_busy_i) begin
				if (dl_word_valid_i) begin
					win_src = SRC_LOADER;
				end
			end else if (pend_q) begin
				win_src = SRC_CHIPSET;
			end
		end else if (viking_slot && viking_active_i && viking_read_i) begin
			win_src = SRC_VIKING;
		end
	end

	// request and take pulse in the cycle after the edge
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			sdram_req_o    <= 1'b0;
			sdram_src_o    <= SRC_NONE;
			dl_word_take_o <= 1'b0;
		end else begin
			sdram_req_o    <= 1'b0;
			dl_word_take_o <= 1'b0;
			if (mhz8_en_i) begin
				sdram_req_o    <= win_src != SRC_NONE;
				sdram_src_o    <= win_src;
				dl_word_take_o <= win_src == SRC_LOADER;
			end
		end
	end

	// payload held until the next edge
	always_ff @(posedge clk_32) begin
		if (mhz8_en_i) begin
			case (win_src)
				SRC_LOADER: begin
					// loader writes both lanes
					sdram_we_o   <= 1'b1;
					sdram_ds_o   <= 2'b11;
					sdram_addr_o <= dl_word_addr_i;
					sdram_din_o  <= dl_word_data_i;
				end
				SRC_VIKING: begin
					sdram_we_o   <= 1'b0;
					sdram_ds_o   <= 2'b11;
					sdram_addr_o <= viking_addr_i;
				end
				SRC_CHIPSET: begin
					sdram_we_o   <= pend_we_q;
					sdram_ds_o   <= pend_ds_q;
					sdram_addr_o <= pend_addr_q;
					sdram_din_o  <= pend_din_q;
				end
				default: begin
					sdram_we_o <= 1'b0;
				end
			endcase
		end
	end

	// loader word must still be there when taken
	a_take_valid: assert property (@(posedge clk_32) disable iff (!xsint)
		dl_word_take_o |-> dl_word_valid_i);

	// one request per slot
	a_req_single: assert property (@(posedge clk_32) disable iff (!xsint)
		sdram_req_o |=> !sdram_req_o);

endmodule

`default_nettype wire

// File: source/st_mem_top.sv
/*
 * memory subsystem top
 * SDRAM request arbitration for chipset, host download and Viking fetch
 */
`timescale 1ns/10ps
`include "st_mem_defs.svh"
`default_nettype none

module st_mem_top
	import st_cfg_pkg::*, st_bus_pkg::*;
(
	input  logic                  clk_32,
	input  logic                  xsint,
	input  logic                  mhz8_en_i,
	input  logic                  turbo_i,
	input  mem_size_e             mem_size_i,
	input  logic                  viking_en_i,
	input  logic                  steroids_i,
	input  logic                  dl_start_i,
	input  dl_target_e            dl_target_i,
	input  logic                  ioctl_wr_i,
	input  logic [24:0]           ioctl_addr_i,
	input  logic [15:0]           ioctl_dout_i,
	input  logic                  dl_end_i,
	input  logic                  ram_ras_n_i,
	input  logic                  ram_we_n_i,
	input  logic                  ram_uds_i,
	input  logic                  ram_lds_i,
	input  logic [`ST_ADDR_W:1]   ram_addr_i,
	input  logic [`ST_DATA_W-1:0] ram_din_i,
	input  logic                  viking_read_i,
	input  logic [`ST_ADDR_W:1]   viking_addr_i,
	input  logic                  cpu_as_n_i,
	input  logic [`ST_ADDR_W:1]   cpu_addr_i,
	input  logic                  rom2_n_i,
	output logic                  sdram_req_o,
	output logic                  sdram_we_o,
	output logic [1:0]            sdram_ds_o,
	output logic [`ST_ADDR_W:1]   sdram_addr_o,
	output logic [`ST_DATA_W-1:0] sdram_din_o,
	output req_src_e              sdram_src_o,
	output logic                  dl_credit_o,
	output logic                  viking_active_o,
	output logic                  tos192k_o,
	output logic [`ST_ADDR_W:1]   rom_addr_o
);

	logic                  viking_enable;
	logic                  ram_en;
	logic                  dl_busy;
	logic                  dl_word_valid;
	logic                  dl_word_take;
	logic [`ST_ADDR_W:1]   dl_word_addr;
	logic [`ST_DATA_W-1:0] dl_word_data;
	logic [`ST_ADDR_W:1]   dl_cur_addr;

	// Viking limits RAM to 8M, steroids moves it out of the way
	assign viking_enable = (viking_en_i && mem_size_i <= MEM_8M) || steroids_i;

	st_ram_window u_ram_window (
		.ram_addr_i      (ram_addr_i),
		.mem_size_i      (mem_size_i),
		.viking_enable_i (viking_enable),
		.steroids_i      (steroids_i),
		.ram_en_o        (ram_en)
	);

	st_dl_loader u_dl_loader (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.dl_start_i      (dl_start_i),
		.dl_target_i     (dl_target_i),
		.ioctl_wr_i      (ioctl_wr_i),
		.ioctl_addr_i    (ioctl_addr_i),
		.ioctl_dout_i    (ioctl_dout_i),
		.dl_end_i        (dl_end_i),
		.dl_word_take_i  (dl_word_take),
		.dl_credit_o     (dl_credit_o),
		.dl_busy_o       (dl_busy),
		.dl_word_valid_o (dl_word_valid),
		.dl_word_addr_o  (dl_word_addr),
		.dl_word_data_o  (dl_word_data),
		.dl_cur_addr_o   (dl_cur_addr)
	);

	st_viking_detect u_viking_detect (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.mhz8_en_i       (mhz8_en_i),
		.cpu_as_n_i      (cpu_as_n_i),
		.cpu_addr_i      (cpu_addr_i),
		.viking_enable_i (viking_enable),
		.steroids_i      (steroids_i),
		.viking_active_o (viking_active_o)
	);

	st_rom_map u_rom_map (
		.clk_32        (clk_32),
		.xsint         (xsint),
		.dl_busy_i     (dl_busy),
		.dl_cur_addr_i (dl_cur_addr),
		.rom2_n_i      (rom2_n_i),
		.cpu_addr_i    (cpu_addr_i),
		.tos192k_o     (tos192k_o),
		.rom_addr_o    (rom_addr_o)
	);

	// slot position is internal to the sequencer here
	st_slot_ctrl u_slot_ctrl (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.mhz8_en_i       (mhz8_en_i),
		.turbo_i         (turbo_i),
		.ram_ras_n_i     (ram_ras_n_i),
		.ram_we_n_i      (ram_we_n_i),
		.ram_uds_i       (ram_uds_i),
		.ram_lds_i       (ram_lds_i),
		.ram_addr_i      (ram_addr_i),
		.ram_din_i       (ram_din_i),
		.ram_en_i        (ram_en),
		.dl_busy_i       (dl_busy),
		.dl_word_valid_i (dl_word_valid),
		.dl_word_addr_i  (dl_word_addr),
		.dl_word_data_i  (dl_word_data),
		.dl_word_take_o  (dl_word_take),
		.viking_active_i (viking_active_o),
		.viking_read_i   (viking_read_i),
		.viking_addr_i   (viking_addr_i),
		.slot_o          (),
		.sdram_req_o     (sdram_req_o),
		.sdram_we_o      (sdram_we_o),
		.sdram_ds_o      (sdram_ds_o),
		.sdram_addr_o    (sdram_addr_o),
		.sdram_din_o     (sdram_din_o),
		.sdram_src_o     (sdram_src_o)
	);

endmodule

`default_nettype wire

// File: test/tb_st_mem.sv
/*
 * memory subsystem testbench
 * replays the trace file and checks SDRAM requests, credits and ROM mapping
 */
`timescale 1ns/10ps
`include "st_mem_defs.svh"
`default_nettype none

module tb_st_mem
	import st_cfg_pkg::*, st_bus_pkg::*;
();

	localparam int DEPTH   = `ST_DL_CREDITS;
	localparam int TIMEOUT = 20000;
	localparam int SETTLE  = 32;

	// DUT inputs
	logic                  clk_32;
	logic                  xsint;
	logic                  mhz8_en_i = 1'b0;
	logic                  turbo_i;
	mem_size_e             mem_size_i;
	logic                  viking_en_i;
	logic                  steroids_i;
	logic                  dl_start_i;
	dl_target_e            dl_target_i;
	logic                  ioctl_wr_i;
	logic [24:0]           ioctl_addr_i;
	logic [15:0]           ioctl_dout_i;
	logic                  dl_end_i;
	logic                  ram_ras_n_i;
	logic                  ram_we_n_i;
	logic                  ram_uds_i;
	logic                  ram_lds_i;
	logic [`ST_ADDR_W:1]   ram_addr_i;
	logic [`ST_DATA_W-1:0] ram_din_i;
	logic                  viking_read_i;
	logic [`ST_ADDR_W:1]   viking_addr_i;
	logic                  cpu_as_n_i;
	logic [`ST_ADDR_W:1]   cpu_addr_i;
	logic                  rom2_n_i;

	// DUT outputs
	logic                  sdram_req_o;
	logic                  sdram_we_o;
	logic [1:0]            sdram_ds_o;
	logic [`ST_ADDR_W:1]   sdram_addr_o;
	logic [`ST_DATA_W-1:0] sdram_din_o;
	req_src_e              sdram_src_o;
	logic                  dl_credit_o;
	logic                  viking_active_o;
	logic                  tos192k_o;
	logic [`ST_ADDR_W:1]   rom_addr_o;

	// request word: src, we, ds, addr, data
	logic [43:0]           req_q [$];
	logic [43:0]           exp_q [$];
	logic [15:0]           host_words [$];

	logic [1:0]            div_q = 2'd0;
	logic [8*32-1:0]       test_name;
	dl_target_e            cur_target;
	logic                  burst;
	logic                  loose_tail;
	logic                  had_download;
	logic                  run_broken;
	int                    words_sent;
	int                    credits_back;
	int                    stalls;
	int                    test_errors;
	int                    total_errors;
	int                    tests_run;
	int                    tests_failed;
	int                    fd;
	int                    code;
	string                 line;

	st_mem_top dut_i (.*);

	initial begin
		clk_32 = 1'b0;
		forever #5 clk_32 = ~clk_32;
	end

	// 8 MHz strobe, one clock in four
	always @(posedge clk_32) begin
		div_q     <= div_q + 2'd1;
		mhz8_en_i <= div_q == 2'd3;
	end

	////////////////////////////////////////////////////////////
	// monitor, samples mid cycle
	////////////////////////////////////////////////////////////

	always @(negedge clk_32) begin
		if (sdram_req_o) begin
			req_q.push_back({sdram_src_o, sdram_we_o, sdram_ds_o, sdram_addr_o, sdram_din_o});
		end
		if (dl_credit_o) begin
			credits_back++;
		end
	end

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %0s %0s: expected %h, actual %h", test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic start_test(input logic [2:0] size, input logic [2:0] target,
		input logic viking_on, input logic burst_on);
		@(posedge clk_32);
		mem_size_i   <= mem_size_e'(size);
		viking_en_i  <= viking_on;
		cur_target   = dl_target_e'(target);
		burst        = burst_on;
		test_errors  = 0;
		loose_tail   = 1'b0;
		had_download = 1'b0;
		words_sent   = 0;
		credits_back = 0;
		stalls       = 0;
		host_words.delete();
		exp_q.delete();
		req_q.delete();
	endtask

	////////////////////////////////////////////////////////////
	// host download with credit accounting
	////////////////////////////////////////////////////////////

	task automatic run_download();
		int idx;
		int gap;
		int n;
		idx = 0;
		gap = 0;
		n = 0;
		had_download = 1'b1;
		@(posedge clk_32);
		dl_start_i  <= 1'b1;
		dl_target_i <= cur_target;
		@(posedge clk_32);
		dl_start_i <= 1'b0;
		while (idx < host_words.size() && n < TIMEOUT) begin
			@(posedge clk_32);
			n++;
			ioctl_wr_i <= 1'b0;
			if (gap > 0) begin
				gap--;
			end else if (DEPTH - words_sent + credits_back <= 0) begin
				// out of credits, hold the word back
				stalls++;
			end else begin
				ioctl_wr_i   <= 1'b1;
				ioctl_addr_i <= 25'(2 * idx);
				ioctl_dout_i <= host_words[idx];
				words_sent++;
				idx++;
				gap = burst ? 0 : int'($urandom % 4);
			end
		end
		@(posedge clk_32);
		ioctl_wr_i <= 1'b0;
		if (idx < host_words.size()) begin
			$display("test %0s: host could not send all download words", test_name);
			test_errors++;
			run_broken = 1'b1;
		end
		// every word, headers too, has to hand its credit back
		n = 0;
		while (credits_back < words_sent && n < TIMEOUT) begin
			@(posedge clk_32);
			n++;
		end
		if (credits_back < words_sent) begin
			$display("test %0s: credits did not come back from the loader", test_name);
			test_errors++;
			run_broken = 1'b1;
		end
		@(posedge clk_32);
		dl_end_i <= 1'b1;
		@(posedge clk_32);
		dl_end_i <= 1'b0;
		if (burst && stalls == 0) begin
			$display("test %0s: burst never had to wait for a credit", test_name);
			test_errors++;
		end
	endtask

	// ras low for two bus slots
	task automatic chipset_access(input logic [23:0] byte_addr, input logic we,
		input logic [15:0] data);
		@(posedge clk_32);
		ram_addr_i  <= byte_addr[23:1];
		ram_we_n_i  <= ~we;
		ram_din_i   <= data;
		ram_ras_n_i <= 1'b0;
		repeat (8) @(posedge clk_32);
		ram_ras_n_i <= 1'b1;
		repeat (8) @(posedge clk_32);
	endtask

	task automatic viking_run(input int strobes, input logic [23:0] win_byte,
		input logic [23:0] fetch_byte);
		int hits;
		int n;
		hits = 0;
		n = 0;
		loose_tail = 1'b1;
		check_value("viking active before probing", 0, viking_active_o);
		@(posedge clk_32);
		cpu_addr_i <= win_byte[23:1];
		cpu_as_n_i <= 1'b0;
		// count the strobes the detector sees with as low
		while (hits < strobes && n < TIMEOUT) begin
			@(posedge clk_32);
			n++;
			if (mhz8_en_i) begin
				hits++;
			end
		end
		cpu_as_n_i <= 1'b1;
		n = 0;
		while (!viking_active_o && n < TIMEOUT) begin
			@(posedge clk_32);
			n++;
		end
		if (!viking_active_o) begin
			$display("test %0s: viking_active_o never rose", test_name);
			test_errors++;
			run_broken = 1'b1;
		end
		viking_addr_i <= fetch_byte[23:1];
		viking_read_i <= 1'b1;
	endtask

	task automatic rom_check(input logic [23:0] cpu_byte, input logic [23:0] rom_byte,
		input logic flag);
		@(posedge clk_32);
		cpu_addr_i <= cpu_byte[23:1];
		rom2_n_i   <= 1'b0;
		@(negedge clk_32);
		check_value("tos192k flag", flag, tos192k_o);
		check_value("rom address", rom_byte[23:1], rom_addr_o);
		@(posedge clk_32);
		rom2_n_i <= 1'b1;
	endtask

	task automatic finish_test();
		int n;
		int i;
		logic [43:0] got_w;
		logic [43:0] exp_w;
		n = 0;
		while (req_q.size() < exp_q.size() && n < TIMEOUT) begin
			@(posedge clk_32);
			n++;
		end
		@(posedge clk_32);
		viking_read_i <= 1'b0;
		if (req_q.size() < exp_q.size()) begin
			$display("test %0s: only %0d of %0d SDRAM requests arrived in time", test_name,
				req_q.size(), exp_q.size());
			test_errors++;
			run_broken = 1'b1;
		end else begin
			// quiet period, stray requests show up here
			repeat (SETTLE) @(posedge clk_32);
			for (i = 0; i < exp_q.size(); i++) begin
				got_w = req_q[i];
				exp_w = exp_q[i];
				check_value($sformatf("req %0d source", i), exp_w[43:42], got_w[43:42]);
				check_value($sformatf("req %0d we", i), exp_w[41], got_w[41]);
				check_value($sformatf("req %0d lanes", i), exp_w[40:39], got_w[40:39]);
				check_value($sformatf("req %0d address", i), exp_w[38:16], got_w[38:16]);
				// reads carry no data
				if (exp_w[41]) begin
					check_value($sformatf("req %0d data", i), exp_w[15:0], got_w[15:0]);
				end
			end
			if (!loose_tail) begin
				check_value("request count", exp_q.size(), req_q.size());
			end
			if (had_download) begin
				check_value("credit pulses", words_sent, credits_back);
			end
		end
		$display("test %0s: %0s, %0d requests, %0d errors", test_name,
			test_errors == 0 ? "ok" : "failed", exp_q.size(), test_errors);
		tests_run++;
		total_errors += test_errors;
		if (test_errors != 0) begin
			tests_failed++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// trace interpreter
	////////////////////////////////////////////////////////////

	task automatic run_command();
		int n;
		logic [8*16-1:0] cmd;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		logic [31:0] f4;
		cmd = '0;
		f1 = '0;
		f2 = '0;
		f3 = '0;
		f4 = '0;
		n = $sscanf(line, "%s", cmd);
		if (n < 1) begin
			return;
		end
		if (cmd == "T") begin
			n = $sscanf(line, "%s %s %h %h %h %h", cmd, test_name, f1, f2, f3, f4);
			start_test(f1[2:0], f2[2:0], f3[0], f4[0]);
		end else if (cmd == "W") begin
			n = $sscanf(line, "%s %h", cmd, f1);
			host_words.push_back(f1[15:0]);
		end else if (cmd == "D") begin
			run_download();
		end else if (cmd == "E") begin
			n = $sscanf(line, "%s %h %h %h %h", cmd, f1, f2, f3, f4);
			exp_q.push_back({f4[1:0], f2[0], 2'b11, f1[22:0], f3[15:0]});
		end else if (cmd == "C") begin
			n = $sscanf(line, "%s %h %h %h", cmd, f1, f2, f3);
			chipset_access(f1[23:0], f2[0], f3[15:0]);
		end else if (cmd == "V") begin
			n = $sscanf(line, "%s %h %h %h", cmd, f1, f2, f3);
			viking_run(int'(f1), f2[23:0], f3[23:0]);
		end else if (cmd == "R") begin
			n = $sscanf(line, "%s %h %h %h", cmd, f1, f2, f3);
			rom_check(f1[23:0], f2[23:0], f3[0]);
		end else if (cmd == "X") begin
			finish_test();
		end else begin
			$display("unknown trace command: %0s", line);
			run_broken = 1'b1;
		end
	endtask

	initial begin
		xsint         <= 1'b0;
		turbo_i       <= 1'b0;
		mem_size_i    <= MEM_1M;
		viking_en_i   <= 1'b0;
		steroids_i    <= 1'b0;
		dl_start_i    <= 1'b0;
		dl_target_i   <= DL_TOS256;
		ioctl_wr_i    <= 1'b0;
		ioctl_addr_i  <= '0;
		ioctl_dout_i  <= '0;
		dl_end_i      <= 1'b0;
		ram_ras_n_i   <= 1'b1;
		ram_we_n_i    <= 1'b1;
		ram_uds_i     <= 1'b1;
		ram_lds_i     <= 1'b1;
		ram_addr_i    <= '0;
		ram_din_i     <= '0;
		viking_read_i <= 1'b0;
		viking_addr_i <= '0;
		cpu_as_n_i    <= 1'b1;
		cpu_addr_i    <= '0;
		rom2_n_i      <= 1'b1;
		run_broken    = 1'b0;
		total_errors  = 0;
		tests_run     = 0;
		tests_failed  = 0;
		test_name     = "reset";
		void'($urandom(98));
		repeat (8) @(posedge clk_32);
		xsint <= 1'b1;
		@(posedge clk_32);
		fd = $fopen("test/st_mem_trace.txt", "r");
		if (fd == 0) begin
			$display("cannot open the trace file test/st_mem_trace.txt");
			run_broken = 1'b1;
		end
		while (fd != 0 && !run_broken && !$feof(fd)) begin
			code = $fgets(line, fd);
			// comment lines start with a hash
			if (code > 0 && line.getc(0) != "#") begin
				run_command();
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
		if (total_errors == 0 && !run_broken && tests_run > 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// last resort if a wait loop is never left
	initial begin
		#2000000;
		$display("simulation ran past its time limit");
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/st_mem_trace.txt
# T name mem_size target viking_en burst | W host word | D run download | X end of test
# E word_addr we data src | C byte_addr we data | V strobes win_byte fetch_byte | R cpu_byte rom_byte tos192
T tos256_words 1 0 0 0
W 1234
W abcd
W 0f0e
W 5a5a
D
E 700000 1 3412 2
E 700001 1 cdab 2
E 700002 1 0e0f 2
E 700003 1 5a5a 2
X
T tos192_burst 1 1 0 1
W 0102
W 0304
W 0506
W 0708
W 090a
W 0b0c
D
E 7e0000 1 0201 2
E 7e0001 1 0403 2
E 7e0002 1 0605 2
E 7e0003 1 0807 2
E 7e0004 1 0a09 2
E 7e0005 1 0c0b 2
R 000100 fc0100 1
X
T pointer_load 1 4 0 0
W 4000
W 0001
W 1111
W 2233
D
E 014000 1 1111 2
E 014001 1 3322 2
X
T window_1m 1 0 0 0
C 0f0000 1 55aa
C 1f0000 1 6666
E 078000 1 55aa 1
X
T viking_fetch 1 0 1 0
V 100 c00000 c01000
E 600800 0 0000 3
E 600800 0 0000 3
X
T tos256_rom 1 0 0 0
W beef
D
E 700000 1 efbe 2
R 000100 e00100 0
X

// File: filelist.f
+incdir+source
source/st_cfg_pkg.sv
source/st_bus_pkg.sv
source/st_ram_window.sv
source/st_dl_loader.sv
source/st_viking_detect.sv
source/st_rom_map.sv
source/st_slot_ctrl.sv
source/st_mem_top.sv
test/tb_st_mem.sv

// File: Makefile
# Verilator build and run for the memory subsystem testbench

VERILATOR  ?= verilator
TOP        ?= tb_st_mem
RTL_TOP    ?= st_mem_top
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

SOURCES := $(wildcard source/*.sv source/*.svh test/*.sv) test/st_mem_trace.txt

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
